// ==== array_drive_pkg.sv ====
/*
 * Array drive package.
 * Widths, value types and stream structs shared along the drive path.
 */
`default_nettype none

package array_drive_pkg;

  localparam int CNT_W  = 9;  // carrier period is 2**CNT_W clocks.
  localparam int CHAN_W = 8;  // up to 256 channels.

  typedef logic [CNT_W-1:0]  cnt_t;
  typedef logic [CNT_W-1:0]  duty_t;   // pulse width in ticks.
  typedef logic [CNT_W-1:0]  phase_t;  // pulse centre in ticks.
  typedef logic [CHAN_W-1:0] chan_t;

  typedef struct packed {
    duty_t  duty;
    phase_t phase;
  } drive_s;

  // host write request.
  typedef struct packed {
    chan_t  chan;
    drive_s drive;
  } host_wr_s;

  // one channel moving down the table to PWM pipeline.
  typedef struct packed {
    chan_t  chan;
    drive_s drive;
  } stream_s;

  typedef enum logic {
    TBL_IDLE,
    TBL_STREAM
  } table_state_e;

endpackage

`default_nettype wire

// ==== time_counter.sv ====
/*
 * Carrier time base.
 * Free-running period counter with a start-of-period strobe
 * and a registered half-period marker.
 */
`timescale 1ns/1ns
`default_nettype none

module time_counter #(
  parameter int WIDTH = 9
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  output array_drive_pkg::cnt_t time_cnt,
  output logic                  period_start,
  output logic                  period_mark
);

  localparam array_drive_pkg::cnt_t HALF = array_drive_pkg::cnt_t'(2 ** (WIDTH - 1));

  if (WIDTH != array_drive_pkg::CNT_W) begin : gen_width_check
    $error("time_counter: WIDTH must match the package counter width");
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      time_cnt <= '0;
    end else begin
      time_cnt <= time_cnt + 1'b1;  // wraps at the period end.
    end
  end

  assign period_start = (time_cnt == '0);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      period_mark <= 1'b0;
    end else begin
      period_mark <= (time_cnt < HALF);  // same timing as pwm_out.
    end
  end

  // the marker rises one cycle after each strobe.
  assert property (@(posedge CLK) disable iff (!rst_n)
    period_start |=> $rose(period_mark));

endmodule

`default_nettype wire

// ==== drive_table.sv ====
/*
 * Drive table.
 * Host-written duty/phase memory, one entry per channel. At each
 * period start all channels stream out in order, one per cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module drive_table #(
  parameter int DEPTH = 8
) (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      wr_valid,
  input  array_drive_pkg::host_wr_s wr,
  output logic                      wr_ready,
  input  logic                      period_start,
  output logic                      tbl_valid,
  output array_drive_pkg::stream_s  tbl
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  array_drive_pkg::drive_s       mem [DEPTH];
  array_drive_pkg::table_state_e state;
  array_drive_pkg::chan_t        rd_ptr;
  logic                          wr_fire;

  assign wr_ready = (state == array_drive_pkg::TBL_IDLE);  // single port memory.
  assign wr_fire  = wr_valid && wr_ready;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_fire && (int'(wr.chan) < DEPTH)) begin
      mem[wr.chan[IDX_W-1:0]] <= wr.drive;  // out of range writes drop.
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state  <= array_drive_pkg::TBL_IDLE;
      rd_ptr <= '0;
    end else begin
      case (state)
        array_drive_pkg::TBL_IDLE: begin
          if (period_start) begin
            state  <= array_drive_pkg::TBL_STREAM;
            rd_ptr <= '0;
          end
        end
        array_drive_pkg::TBL_STREAM: begin
          if (rd_ptr == array_drive_pkg::chan_t'(DEPTH - 1)) begin
            state <= array_drive_pkg::TBL_IDLE;
          end else begin
            rd_ptr <= rd_ptr + 1'b1;
          end
        end
        default: state <= array_drive_pkg::TBL_IDLE;
      endcase
    end
  end

  assign tbl_valid  = (state == array_drive_pkg::TBL_STREAM);
  assign tbl.chan   = rd_ptr;
  assign tbl.drive  = mem[rd_ptr[IDX_W-1:0]];

  // the host window only closes right after a period start.
  assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(wr_ready) |-> $past(period_start));

  assert property (@(posedge CLK) disable iff (!rst_n)
    tbl_valid |-> (int'(tbl.chan) < DEPTH));

endmodule

`default_nettype wire

// ==== phase_silencer.sv ====
/*
 * Phase silencer.
 * Limits how far each channel's duty and phase move per update.
 * Phase moves the short way round the carrier circle.
 */
`timescale 1ns/1ns
`default_nettype none

module phase_silencer #(
  parameter int DEPTH = 8
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  array_drive_pkg::duty_t   step,
  input  logic                     tbl_valid,
  input  array_drive_pkg::stream_s tbl,
  output logic                     sil_valid,
  output array_drive_pkg::stream_s sil
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam array_drive_pkg::phase_t HALF =
    array_drive_pkg::phase_t'(2 ** (array_drive_pkg::CNT_W - 1));

  array_drive_pkg::drive_s cur_mem [DEPTH];
  array_drive_pkg::drive_s cur;
  array_drive_pkg::drive_s tgt;
  array_drive_pkg::drive_s nxt;
  array_drive_pkg::phase_t ph_fwd;
  array_drive_pkg::phase_t ph_back;
  array_drive_pkg::phase_t ph_step;

  always_comb begin
    cur     = cur_mem[tbl.chan[IDX_W-1:0]];
    tgt     = tbl.drive;
    nxt     = tgt;
    ph_step = array_drive_pkg::phase_t'(step);
    ph_fwd  = tgt.phase - cur.phase;  // modulo the period.
    ph_back = cur.phase - tgt.phase;

    if (tgt.duty > cur.duty) begin
      if (tgt.duty - cur.duty > step) nxt.duty = cur.duty + step;
    end else if (cur.duty - tgt.duty > step) begin
      nxt.duty = cur.duty - step;
    end

    // a tie at half a circle goes upward.
    if (ph_fwd <= HALF) begin
      if (ph_fwd > ph_step) nxt.phase = cur.phase + ph_step;
    end else if (ph_back > ph_step) begin
      nxt.phase = cur.phase - ph_step;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        cur_mem[i] <= '0;
      end
    end else if (tbl_valid) begin
      cur_mem[tbl.chan[IDX_W-1:0]] <= nxt;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sil_valid <= 1'b0;
    end else begin
      sil_valid <= tbl_valid;
    end
  end

  always_ff @(posedge CLK) begin
    sil.chan  <= tbl.chan;
    sil.drive <= nxt;
  end

endmodule

`default_nettype wire

// ==== pwm_bank.sv ====
/*
 * PWM bank.
 * Shadow and active drive registers per channel and one
 * centred-pulse comparator per output pin.
 */
`timescale 1ns/1ns
`default_nettype none

module pwm_bank #(
  parameter int DEPTH = 8
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  array_drive_pkg::cnt_t    time_cnt,
  input  logic                     period_start,
  input  logic                     sil_valid,
  input  array_drive_pkg::stream_s sil,
  output logic                     pwm_out [DEPTH]
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  array_drive_pkg::drive_s shadow  [DEPTH];
  array_drive_pkg::drive_s active  [DEPTH];
  array_drive_pkg::drive_s act_nxt [DEPTH];
  array_drive_pkg::cnt_t   rise    [DEPTH];
  array_drive_pkg::cnt_t   offs    [DEPTH];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        shadow[i] <= '0;
      end
    end else if (sil_valid) begin
      shadow[sil.chan[IDX_W-1:0]] <= sil.drive;
    end
  end

  // new values already apply to count zero of the period.
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      act_nxt[i] = period_start ? shadow[i] : active[i];
      rise[i]    = act_nxt[i].phase - (act_nxt[i].duty >> 1);
      offs[i]    = time_cnt - rise[i];
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        active[i]  <= '0;
        pwm_out[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        active[i]  <= act_nxt[i];
        pwm_out[i] <= (offs[i] < act_nxt[i].duty);  // zero duty never fires.
      end
    end
  end

  // streaming has to finish inside the period it started in.
  assert property (@(posedge CLK) disable iff (!rst_n)
    !(sil_valid && period_start));

endmodule

`default_nettype wire

// ==== array_drive_top.sv ====
/*
 * Phased-array drive path.
 * Time base, host drive table, slew silencer and PWM output bank.
 */
`timescale 1ns/1ns
`default_nettype none

module array_drive_top #(
  parameter int WIDTH = 9,
  parameter int DEPTH = 8
) (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      wr_valid,
  input  array_drive_pkg::host_wr_s wr,
  output logic                      wr_ready,
  input  array_drive_pkg::duty_t    step,
  output logic                      pwm_out [DEPTH],
  output logic                      period_mark
);

  array_drive_pkg::cnt_t    time_cnt;
  logic                     period_start;
  logic                     tbl_valid;
  array_drive_pkg::stream_s tbl;
  logic                     sil_valid;
  array_drive_pkg::stream_s sil;

  time_counter #(
    .WIDTH(WIDTH)
  ) u_time_counter (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .time_cnt     (time_cnt),
    .period_start (period_start),
    .period_mark  (period_mark)
  );

  drive_table #(
    .DEPTH(DEPTH)
  ) u_drive_table (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .wr_valid     (wr_valid),
    .wr           (wr),
    .wr_ready     (wr_ready),
    .period_start (period_start),
    .tbl_valid    (tbl_valid),
    .tbl          (tbl)
  );

  phase_silencer #(
    .DEPTH(DEPTH)
  ) u_phase_silencer (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .step      (step),
    .tbl_valid (tbl_valid),
    .tbl       (tbl),
    .sil_valid (sil_valid),
    .sil       (sil)
  );

  pwm_bank #(
    .DEPTH(DEPTH)
  ) u_pwm_bank (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .time_cnt     (time_cnt),
    .period_start (period_start),
    .sil_valid    (sil_valid),
    .sil          (sil),
    .pwm_out      (pwm_out)
  );

endmodule

`default_nettype wire

// ==== tb_array_drive.sv ====
/*
 * Testbench for the phased-array drive path.
 * Replays host commands from a data file and measures pulse width
 * and rise offset per channel over one carrier period.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_array_drive;

  localparam int DEPTH   = 8;
  localparam int PERIOD  = 512;
  localparam int TIMEOUT = 2000;

  logic                      CLK;
  logic                      rst_n;
  logic                      wr_valid;
  array_drive_pkg::host_wr_s wr;
  logic                      wr_ready;
  array_drive_pkg::duty_t    step;
  logic                      pwm_out [DEPTH];
  logic                      period_mark;

  int error_cnt;
  int stall_cycles;
  bit run_aborted;

  array_drive_top #(
    .WIDTH(9),
    .DEPTH(DEPTH)
  ) u_array_drive_top (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .wr_valid    (wr_valid),
    .wr          (wr),
    .wr_ready    (wr_ready),
    .step        (step),
    .pwm_out     (pwm_out),
    .period_mark (period_mark)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic check_value(string name, int expected, int actual);
    if (expected != actual) begin
      error_cnt++;
      $display("** Error: %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;  // outputs are settled here.
  endtask

  task automatic wait_mark_rise();
    logic prev;
    if (run_aborted) return;
    prev = period_mark;
    for (int cycles = 0; cycles < TIMEOUT; cycles++) begin
      next_cycle();
      if (period_mark && !prev) return;
      prev = period_mark;
    end
    $display("timeout while waiting for period_mark to rise");
    run_aborted = 1'b1;
  endtask

  task automatic host_write(int chan, int duty, int phase);
    int gap;
    int cycles;
    gap = 1 + int'($urandom % 4);
    repeat (gap) next_cycle();
    wr_valid          = 1'b1;
    wr.chan           = array_drive_pkg::chan_t'(chan);
    wr.drive.duty     = array_drive_pkg::duty_t'(duty);
    wr.drive.phase    = array_drive_pkg::phase_t'(phase);
    cycles            = 0;
    while (!wr_ready && cycles < TIMEOUT) begin
      stall_cycles++;  // table is streaming.
      next_cycle();
      cycles++;
    end
    if (!wr_ready) begin
      $display("timeout while waiting for wr_ready on channel %0d", chan);
      run_aborted = 1'b1;
    end else begin
      next_cycle();
    end
    wr_valid = 1'b0;
  endtask

  // one period from the mark edge, treated as a circle for the rise.
  task automatic measure_channel(int chan, output int width, output int rise);
    logic hist [PERIOD];
    width = 0;
    rise  = PERIOD;  // no rising edge seen.
    wait_mark_rise();
    if (run_aborted) return;
    for (int k = 0; k < PERIOD; k++) begin
      if (k > 0) next_cycle();
      hist[k] = pwm_out[chan];
    end
    for (int k = 0; k < PERIOD; k++) begin
      if (hist[k]) width++;
      if (hist[k] && !hist[(k + PERIOD - 1) % PERIOD] && rise == PERIOD) rise = k;
    end
  endtask

  task automatic check_reset_quiet();
    int high_cnt;
    high_cnt = 0;
    check_value("reset wr_ready", 1, int'(wr_ready));
    wait_mark_rise();
    for (int k = 0; k < 2 * PERIOD && !run_aborted; k++) begin
      if (k > 0) next_cycle();
      for (int i = 0; i < DEPTH; i++) begin
        if (pwm_out[i]) high_cnt++;
      end
    end
    check_value("reset pwm_out quiet", 0, high_cnt);
  endtask

  task automatic report_bad_line(int cmd);
    $display("malformed data line for command %c", cmd[7:0]);
    run_aborted = 1'b1;
  endtask

  initial begin
    int fd;
    int c;
    int n;
    int a;
    int b;
    int d;
    int width;
    int rise;
    error_cnt    = 0;
    stall_cycles = 0;
    run_aborted  = 1'b0;
    rst_n        = 1'b0;
    wr_valid     = 1'b0;
    wr           = '0;
    step         = '0;
    void'($urandom(32'h1019));
    repeat (5) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    check_reset_quiet();
    fd = $fopen("array_drive_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open array_drive_testdata.txt");
      run_aborted = 1'b1;
    end
    while (!run_aborted) begin
      c = $fgetc(fd);
      if (c == -1) break;
      case (c)
        int'("#"): begin
          while (c != int'("\n") && c != -1) c = $fgetc(fd);
        end
        int'("S"): begin
          n = $fscanf(fd, "%d", a);
          if (n == 1) step = array_drive_pkg::duty_t'(a);
          else report_bad_line(c);
        end
        int'("W"): begin
          n = $fscanf(fd, "%d %d %d", a, b, d);
          if (n == 3) host_write(a, b, d);
          else report_bad_line(c);
        end
        int'("P"): begin
          n = $fscanf(fd, "%d", a);
          if (n == 1) repeat (a) wait_mark_rise();
          else report_bad_line(c);
        end
        int'("E"): begin
          n = $fscanf(fd, "%d %d %d", a, b, d);
          if (n == 3) begin
            measure_channel(a, width, rise);
            check_value($sformatf("ch%0d width", a), b, width);
            check_value($sformatf("ch%0d rise", a), d, rise);
          end else begin
            report_bad_line(c);
          end
        end
        default: ;  // whitespace between commands.
      endcase
    end
    if (fd != 0) $fclose(fd);
    check_value("host write stalled", 1, int'(stall_cycles > 0));
    $display("Errors: %0d", error_cnt + int'(run_aborted));
    if (error_cnt == 0 && !run_aborted) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== array_drive_testdata.txt ====
# commands: S step | W chan duty phase | P periods | E chan width rise
# rise is the first high offset after period_mark rises, 512 means no pulse
S 511
W 0 0 100
W 1 511 300
W 2 100 200
W 3 64 10
W 4 37 450
W 5 0 0
W 6 20 100
W 7 200 256
W 9 300 300
P 2
E 0 0 512
E 1 511 45
E 2 100 150
E 3 64 490
E 4 37 432
E 5 0 512
E 6 20 90
E 7 200 156
# duty slew on channel 5
S 50
W 5 150 0
P 1
E 5 50 487
E 5 100 462
E 5 150 437
# phase jump of 300 goes the short way down
S 100
W 6 20 400
P 1
E 6 20 502
E 6 20 402
E 6 20 390

// ==== array_drive_top.f ====
array_drive_pkg.sv
time_counter.sv
drive_table.sv
phase_silencer.sv
pwm_bank.sv
array_drive_top.sv
tb_array_drive.sv

// ==== Makefile ====
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f array_drive_top.f \
	  --top-module tb_array_drive --Mdir $(OBJ_DIR) -o sim_tb

run: compile
	./$(OBJ_DIR)/sim_tb | tee $(LOG)
	@! grep -q "Verification failed" $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
